// File: PipelineCore.f
source/CorePkg.sv
source/StageReg.sv
source/FetchUnit.sv
source/DecodeStage.sv
source/ExecuteStage.sv
source/MemAccess.sv
source/HazardUnit.sv
source/PipelineCore.sv
verification/WishboneMemModel.sv
verification/PipelineCoreTb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module PipelineCoreTb -f PipelineCore.f -o PipelineCoreTb
	./obj_dir/PipelineCoreTb | tee sim.log
	grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// File: verification/PipelineCoreTb.sv
`timescale 1ns/10ps

module PipelineCoreTb;

    localparam int          BASE_TESTS     = 6;
    localparam int          NUM_TESTS      = 2 * BASE_TESTS;
    localparam int          TIMEOUT_CYCLES = NUM_TESTS * 400;
    localparam logic [31:0] RAND_SEED      = 32'h9ad;
    localparam logic [31:0] RESET_PC       = 32'h0;

    logic           clk;
    logic           reset;
    logic           waitEn;
    CorePkg::WbReqT ibusReq;
    CorePkg::WbReqT dbusReq;
    logic           ibusAck;
    logic           dbusAck;
    logic [31:0]    ibusDat;
    logic [31:0]    dbusDat;

    // Test table
    string       testName [NUM_TESTS];
    logic [31:0] progWords [NUM_TESTS][16];
    int          progLen [NUM_TESTS];
    logic [31:0] expAdr [NUM_TESTS][4];
    logic [31:0] expDat [NUM_TESTS][4];
    int          expCount [NUM_TESTS];
    bit          withWaits [NUM_TESTS];

    logic [31:0] storeAdrQ [$];
    logic [31:0] storeDatQ [$];
    string       curName;
    int          errorCount;
    int          cycleCount;
    int          testsPassed;
    int          testsFailed;

    PipelineCore #(
        .RESET_PC(RESET_PC)
    ) u_dut (
        .i_Clk     (clk),
        .i_reset   (reset),
        .o_ibusReq (ibusReq),
        .i_ibusAck (ibusAck),
        .i_ibusDat (ibusDat),
        .o_dbusReq (dbusReq),
        .i_dbusAck (dbusAck),
        .i_dbusDat (dbusDat)
    );

    WishboneMemModel #(.SEED(RAND_SEED)) u_imem (
        .i_Clk(clk), .i_reset(reset), .i_waitEn(waitEn),
        .i_req(ibusReq), .o_ack(ibusAck), .o_dat(ibusDat)
    );

    WishboneMemModel #(.SEED(RAND_SEED ^ 32'h1)) u_dmem (
        .i_Clk(clk), .i_reset(reset), .i_waitEn(waitEn),
        .i_req(dbusReq), .o_ack(dbusAck), .o_dat(dbusDat)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // RV32I encodings
    function automatic logic [31:0] encAddi(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] encAdd(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encLw(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] encSw(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encBeq(input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    // Initial data memory contents
    function automatic logic [31:0] fillWord(input logic [31:0] byteAdr);
        return ~byteAdr ^ 32'h5a5a_0000;
    endfunction

    task automatic addWord(input int t, input logic [31:0] word);
        progWords[t][progLen[t]] = word;
        progLen[t]++;
    endtask

    task automatic addStore(input int t, input logic [31:0] adr, input logic [31:0] dat);
        expAdr[t][expCount[t]] = adr;
        expDat[t][expCount[t]] = dat;
        expCount[t]++;
    endtask

    task automatic buildTable();
        for (int t = 0; t < NUM_TESTS; t++) begin
            progLen[t] = 0;
            expCount[t] = 0;
            withWaits[t] = 1'b0;
        end
        testName[0] = "alu_forwarding";
        addWord(0, encAddi(5'd1, 5'd0, 12'd5));
        addWord(0, encAddi(5'd2, 5'd1, 12'd7));
        addWord(0, encAdd(5'd3, 5'd1, 5'd2));
        addWord(0, encAdd(5'd4, 5'd3, 5'd3));
        addWord(0, encAddi(5'd5, 5'd4, 12'hfd8));
        addWord(0, encSw(5'd3, 5'd0, 12'h040));
        addWord(0, encSw(5'd4, 5'd0, 12'h044));
        addWord(0, encSw(5'd5, 5'd0, 12'h048));
        addStore(0, 32'h40, 32'd17);
        addStore(0, 32'h44, 32'd34);
        addStore(0, 32'h48, 32'hffff_fffa);

        testName[1] = "load_use_adjacent";
        addWord(1, encAddi(5'd3, 5'd0, 12'd100));
        addWord(1, encLw(5'd1, 5'd0, 12'h020));
        addWord(1, encAdd(5'd2, 5'd1, 5'd3));
        addWord(1, encSw(5'd2, 5'd0, 12'h040));
        addWord(1, encLw(5'd4, 5'd0, 12'h040));
        addWord(1, encSw(5'd4, 5'd0, 12'h04c));
        addStore(1, 32'h40, 32'ha5a6_0043);
        addStore(1, 32'h4c, 32'ha5a6_0043);

        testName[2] = "load_use_gap1";
        addWord(2, encAddi(5'd3, 5'd0, 12'd100));
        addWord(2, encLw(5'd1, 5'd0, 12'h024));
        addWord(2, encAddi(5'd6, 5'd0, 12'd1));
        addWord(2, encAdd(5'd2, 5'd1, 5'd3));
        addWord(2, encSw(5'd2, 5'd0, 12'h044));
        addStore(2, 32'h44, 32'ha5a6_003f);

        testName[3] = "load_use_gap2";
        addWord(3, encAddi(5'd3, 5'd0, 12'd100));
        addWord(3, encLw(5'd1, 5'd0, 12'h028));
        addWord(3, encAddi(5'd6, 5'd0, 12'd1));
        addWord(3, encAddi(5'd7, 5'd0, 12'd2));
        addWord(3, encAdd(5'd2, 5'd1, 5'd3));
        addWord(3, encSw(5'd2, 5'd0, 12'h048));
        addStore(3, 32'h48, 32'ha5a6_003b);

        // Same shape, only the compared values differ
        testName[4] = "branch_taken";
        testName[5] = "branch_not_taken";
        for (int t = 4; t < 6; t++) begin
            addWord(t, encAddi(5'd1, 5'd0, 12'd3));
            addWord(t, encAddi(5'd2, 5'd0, (t == 4) ? 12'd3 : 12'd4));
            addWord(t, encBeq(5'd1, 5'd2, 13'd12));
            addWord(t, encSw(5'd1, 5'd0, 12'h040));
            addWord(t, encSw(5'd2, 5'd0, 12'h044));
            addWord(t, encSw(5'd1, 5'd0, 12'h048));
        end
        addStore(4, 32'h48, 32'd3);
        addStore(5, 32'h40, 32'd3);
        addStore(5, 32'h44, 32'd4);
        addStore(5, 32'h48, 32'd3);

        // Every program ends in a branch to itself
        for (int t = 0; t < BASE_TESTS; t++) begin
            addWord(t, encBeq(5'd0, 5'd0, 13'd0));
        end

        // Second half repeats the programs with bus wait states
        for (int t = 0; t < BASE_TESTS; t++) begin
            testName[t + BASE_TESTS] = {testName[t], "_waits"};
            withWaits[t + BASE_TESTS] = 1'b1;
            progLen[t + BASE_TESTS] = progLen[t];
            expCount[t + BASE_TESTS] = expCount[t];
            for (int i = 0; i < 16; i++) begin
                progWords[t + BASE_TESTS][i] = progWords[t][i];
            end
            for (int i = 0; i < 4; i++) begin
                expAdr[t + BASE_TESTS][i] = expAdr[t][i];
                expDat[t + BASE_TESTS][i] = expDat[t][i];
            end
        end
    endtask

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error %s, %s: expected 0x%08h, actual 0x%08h",
                     curName, what, expected, actual);
            errorCount++;
        end
    endtask

    task automatic loadMemories(input int t);
        logic [31:0] word;
        for (int i = 0; i < 64; i++) begin
            word = 32'h0;
            if (i < progLen[t]) begin
                word = progWords[t][i];
            end
            u_imem.writeWord(i[5:0], word);
            u_dmem.writeWord(i[5:0], fillWord({i[29:0], 2'b00}));
        end
    endtask

    task automatic runTest(input int t);
        logic [31:0] haltAdr;
        logic [31:0] prevAdr;
        bit          done;
        int          nGot;
        haltAdr = RESET_PC + 32'(4 * (progLen[t] - 1));
        prevAdr = 32'hffff_ffff;
        done = 1'b0;
        storeAdrQ.delete();
        storeDatQ.delete();

        @(negedge clk);
        reset = 1'b1;
        waitEn = withWaits[t];
        loadMemories(t);
        // Reset held for three cycles
        for (int c = 0; c < 3; c++) begin
            @(negedge clk);
            checkValue("ibus cyc around reset", 32'd0, {31'd0, ibusReq.cycStb});
            checkValue("dbus cyc around reset", 32'd0, {31'd0, dbusReq.cycStb});
        end
        reset = 1'b0;
        // First cycle after reset, outputs still idle
        checkValue("ibus cyc after reset", 32'd0, {31'd0, ibusReq.cycStb});
        checkValue("dbus cyc after reset", 32'd0, {31'd0, dbusReq.cycStb});
        @(negedge clk);
        checkValue("first fetch cyc", 32'd1, {31'd0, ibusReq.cycStb});
        checkValue("first fetch address", RESET_PC, ibusReq.adr);

        // Record stores until the halt branch has redirected to itself
        while (!done) begin
            if (ibusReq.cycStb) begin
                checkValue("ibus write enable", 32'd0, {31'd0, ibusReq.we});
                checkValue("ibus write data", 32'd0, ibusReq.datW);
            end
            if (dbusReq.cycStb && dbusReq.we && dbusAck) begin
                storeAdrQ.push_back(dbusReq.adr);
                storeDatQ.push_back(dbusReq.datW);
            end
            if (ibusReq.cycStb && ibusAck) begin
                if (ibusReq.adr == haltAdr && prevAdr != haltAdr - 32'd4) begin
                    done = 1'b1;
                end
                prevAdr = ibusReq.adr;
            end
            if (!done) begin
                @(negedge clk);
            end
        end

        nGot = storeAdrQ.size();
        for (int i = 0; i < expCount[t] || i < nGot; i++) begin
            if (i >= nGot) begin
                $display("%s: store %0d to 0x%08h never happened", curName, i, expAdr[t][i]);
                errorCount++;
            end else if (i >= expCount[t]) begin
                $display("%s: unexpected extra store of 0x%08h to 0x%08h",
                         curName, storeDatQ[i], storeAdrQ[i]);
                errorCount++;
            end else begin
                checkValue($sformatf("store %0d address", i), expAdr[t][i], storeAdrQ[i]);
                checkValue($sformatf("store %0d data", i), expDat[t][i], storeDatQ[i]);
            end
        end
    endtask

    initial begin
        int errorsBefore;
        reset = 1'b1;
        waitEn = 1'b0;
        errorCount = 0;
        testsPassed = 0;
        testsFailed = 0;
        curName = "setup";
        buildTable();
        for (int t = 0; t < NUM_TESTS; t++) begin
            curName = testName[t];
            errorsBefore = errorCount;
            runTest(t);
            if (errorCount == errorsBefore) begin
                testsPassed++;
                $display("Test %0d %s: pass", t, curName);
            end else begin
                testsFailed++;
                $display("Test %0d %s: fail, %0d errors", t, curName, errorCount - errorsBefore);
            end
        end
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 NUM_TESTS, testsPassed, testsFailed, errorCount);
        if (testsFailed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog over the whole run
    initial begin
        cycleCount = 0;
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, %s never reached its halt loop", cycleCount, curName);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: verification/WishboneMemModel.sv
`timescale 1ns/10ps

module WishboneMemModel #(
    parameter int          ADDR_BITS = 6,
    parameter logic [31:0] SEED      = 32'h0
) (
    input  logic                     i_Clk,
    input  logic                     i_reset,
    input  logic                     i_waitEn,
    input  CorePkg::WbReqT           i_req,
    output logic                     o_ack,
    output logic [CorePkg::XLEN-1:0] o_dat
);

    logic [CorePkg::XLEN-1:0] mem [2**ADDR_BITS];
    logic [ADDR_BITS-1:0]     w_index;
    logic [1:0]               r_waitLeft;
    logic                     r_ack = 1'b0;
    logic [CorePkg::XLEN-1:0] r_dat = '0;
    logic [31:0]              randWord;
    integer                   seed;

    initial begin
        seed = SEED;
    end

    // Word addressed, upper address bits are ignored
    assign w_index = i_req.adr[ADDR_BITS+1:2];
    assign o_ack = r_ack;
    assign o_dat = r_dat;

    // Loads one word before a run
    task automatic writeWord(input logic [ADDR_BITS-1:0] index, input logic [31:0] value);
        mem[index] = value;
    endtask

    always @(posedge i_Clk) begin
        if (i_reset) begin
            r_ack <= 1'b0;
            r_waitLeft <= 2'd0;
        end else begin
            r_ack <= 1'b0;
            // One ack per request, never in the cycle right after an ack
            if (i_req.cycStb && !r_ack) begin
                if (r_waitLeft != 2'd0) begin
                    r_waitLeft <= r_waitLeft - 2'd1;
                end else begin
                    r_ack <= 1'b1;
                    r_dat <= mem[w_index];
                    if (i_req.we) begin
                        mem[w_index] = i_req.datW;
                    end
                    // Wait states for the next access, 0 to 3
                    randWord = $random(seed);
                    r_waitLeft <= i_waitEn ? randWord[1:0] : 2'd0;
                end
            end
        end
    end

endmodule

// File: source/PipelineCore.sv
`timescale 1ns/10ps

module PipelineCore #(
    parameter logic [CorePkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                     i_Clk,
    input  logic                     i_reset,
    output CorePkg::WbReqT           o_ibusReq,
    input  logic                     i_ibusAck,
    input  logic [CorePkg::XLEN-1:0] i_ibusDat,
    output CorePkg::WbReqT           o_dbusReq,
    input  logic                     i_dbusAck,
    input  logic [CorePkg::XLEN-1:0] i_dbusDat
);

    CorePkg::DecodePayloadT w_fetched;
    CorePkg::DecodePayloadT w_dIn;
    CorePkg::DecodePayloadT w_dQ;
    CorePkg::ExecPayloadT   w_decoded;
    CorePkg::ExecPayloadT   w_eQ;
    CorePkg::MemPayloadT    w_executed;
    CorePkg::MemPayloadT    w_mQ;
    CorePkg::MemPayloadT    w_memOut;
    CorePkg::MemPayloadT    w_wQ;
    logic w_fetchValid;
    logic w_fetchWait;
    logic w_dbusBusy;
    logic w_pcEn;
    logic w_redirect;
    logic w_rs1Valid;
    logic w_rs2Valid;
    logic w_enD;
    logic w_enE;
    logic w_enM;
    logic w_enW;
    logic w_clrD;
    logic w_clrE;
    logic w_clrM;
    logic w_clrW;

    FetchUnit #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .i_Clk        (i_Clk),
        .i_reset      (i_reset),
        .i_pcEn       (w_pcEn),
        .i_redirect   (w_redirect),
        .i_redirectPc (w_mQ.branchTarget),
        .i_ibusAck    (i_ibusAck),
        .i_ibusDat    (i_ibusDat),
        .o_ibusReq    (o_ibusReq),
        .o_fetched    (w_fetched),
        .o_fetchValid (w_fetchValid),
        .o_waitReq    (w_fetchWait)
    );

    // Only a real fetched word may enter decode
    assign w_dIn = w_fetchValid ? w_fetched : '0;

    StageReg #(.PayloadT(CorePkg::DecodePayloadT)) u_regD (
        .i_Clk(i_Clk), .i_reset(i_reset), .i_en(w_enD), .i_clr(w_clrD),
        .i_d(w_dIn), .o_q(w_dQ)
    );

    DecodeStage u_decode (
        .i_Clk      (i_Clk),
        .i_reset    (i_reset),
        .i_in       (w_dQ),
        .i_wbWe     (w_wQ.writesRd),
        .i_wbRd     (w_wQ.rd),
        .i_wbData   (w_wQ.aluResult),
        .o_out      (w_decoded),
        .o_rs1Valid (w_rs1Valid),
        .o_rs2Valid (w_rs2Valid)
    );

    StageReg #(.PayloadT(CorePkg::ExecPayloadT)) u_regE (
        .i_Clk(i_Clk), .i_reset(i_reset), .i_en(w_enE), .i_clr(w_clrE),
        .i_d(w_decoded), .o_q(w_eQ)
    );

    ExecuteStage u_execute (
        .i_in   (w_eQ),
        .i_fwdM (w_mQ),
        .i_fwdW (w_wQ),
        .o_out  (w_executed)
    );

    StageReg #(.PayloadT(CorePkg::MemPayloadT)) u_regM (
        .i_Clk(i_Clk), .i_reset(i_reset), .i_en(w_enM), .i_clr(w_clrM),
        .i_d(w_executed), .o_q(w_mQ)
    );

    MemAccess u_memAccess (
        .i_Clk     (i_Clk),
        .i_reset   (i_reset),
        .i_in      (w_mQ),
        .i_dbusAck (i_dbusAck),
        .i_dbusDat (i_dbusDat),
        .o_dbusReq (o_dbusReq),
        .o_busy    (w_dbusBusy),
        .o_out     (w_memOut)
    );

    StageReg #(.PayloadT(CorePkg::MemPayloadT)) u_regW (
        .i_Clk(i_Clk), .i_reset(i_reset), .i_en(w_enW), .i_clr(w_clrW),
        .i_d(w_memOut), .o_q(w_wQ)
    );

    HazardUnit u_hazard (
        .i_Clk        (i_Clk),
        .i_reset      (i_reset),
        .i_rs1        (w_decoded.rs1),
        .i_rs1Valid   (w_rs1Valid),
        .i_rs2        (w_decoded.rs2),
        .i_rs2Valid   (w_rs2Valid),
        .i_rdE        (w_eQ.rd),
        .i_isLoadE    (w_eQ.isLoad),
        .i_rdM        (w_mQ.rd),
        .i_isLoadM    (w_mQ.isLoad),
        .i_rdW        (w_wQ.rd),
        .i_isLoadW    (w_wQ.isLoad),
        .i_ibusWait   (w_fetchWait),
        .i_dbusBusy   (w_dbusBusy),
        .i_takeBranch (w_mQ.takeBranch),
        .o_pcEn       (w_pcEn),
        .o_redirect   (w_redirect),
        .o_regEnD     (w_enD),
        .o_regEnE     (w_enE),
        .o_regEnM     (w_enM),
        .o_regEnW     (w_enW),
        .o_regClrD    (w_clrD),
        .o_regClrE    (w_clrE),
        .o_regClrM    (w_clrM),
        .o_regClrW    (w_clrW)
    );

endmodule

// File: source/HazardUnit.sv
`timescale 1ns/10ps

module HazardUnit (
    input  logic             i_Clk,
    input  logic             i_reset,
    input  CorePkg::RegAddrT i_rs1,
    input  logic             i_rs1Valid,
    input  CorePkg::RegAddrT i_rs2,
    input  logic             i_rs2Valid,
    input  CorePkg::RegAddrT i_rdE,
    input  logic             i_isLoadE,
    input  CorePkg::RegAddrT i_rdM,
    input  logic             i_isLoadM,
    input  CorePkg::RegAddrT i_rdW,
    input  logic             i_isLoadW,
    input  logic             i_ibusWait,
    input  logic             i_dbusBusy,
    input  logic             i_takeBranch,
    output logic             o_pcEn,
    output logic             o_redirect,
    output logic             o_regEnD,
    output logic             o_regEnE,
    output logic             o_regEnM,
    output logic             o_regEnW,
    output logic             o_regClrD,
    output logic             o_regClrE,
    output logic             o_regClrM,
    output logic             o_regClrW
);

    logic r_redirectDone;
    logic w_hazE;
    logic w_hazM;
    logic w_hazW;
    logic w_bypassW;

    // Decode reads the destination of a load further down the pipe
    assign w_hazE = i_isLoadE && ((i_rs1Valid && i_rs1 == i_rdE) ||
                                  (i_rs2Valid && i_rs2 == i_rdE));
    assign w_hazM = i_isLoadM && ((i_rs1Valid && i_rs1 == i_rdM) ||
                                  (i_rs2Valid && i_rs2 == i_rdM));
    assign w_hazW = i_isLoadW && ((i_rs1Valid && i_rs1 == i_rdW) ||
                                  (i_rs2Valid && i_rs2 == i_rdW));

    // A load in writeback reaches decode through the register file bypass
    assign w_bypassW = w_hazW && !w_hazE && !w_hazM;

    always_comb begin
        o_pcEn = 1'b1;
        o_redirect = 1'b0;
        o_regEnD = 1'b1;
        o_regEnE = 1'b1;
        o_regEnM = 1'b1;
        o_regEnW = 1'b1;
        o_regClrD = 1'b0;
        o_regClrE = 1'b0;
        o_regClrM = 1'b0;
        o_regClrW = 1'b0;

        if (i_dbusBusy) begin
            // Data bus waiting, freeze everything
            o_pcEn = 1'b0;
            o_regEnD = 1'b0;
            o_regEnE = 1'b0;
            o_regEnM = 1'b0;
            o_regEnW = 1'b0;
        end else if (i_takeBranch) begin
            // Squash the three younger instructions
            o_redirect = !r_redirectDone;
            o_regClrD = 1'b1;
            o_regClrE = 1'b1;
            o_regClrM = 1'b1;
        end else if ((w_hazE || w_hazM || w_hazW) && !w_bypassW) begin
            o_pcEn = 1'b0;
            o_regEnD = 1'b0;
            o_regClrE = 1'b1;
        end

        // No instruction from fetch, so decode gets a bubble
        if (i_ibusWait && o_regEnD) begin
            o_regClrD = 1'b1;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (i_reset) begin
            r_redirectDone <= 1'b0;
        end else begin
            r_redirectDone <= o_redirect;
        end
    end

endmodule

// File: source/MemAccess.sv
`timescale 1ns/10ps

module MemAccess (
    input  logic                     i_Clk,
    input  logic                     i_reset,
    input  CorePkg::MemPayloadT      i_in,
    input  logic                     i_dbusAck,
    input  logic [CorePkg::XLEN-1:0] i_dbusDat,
    output CorePkg::WbReqT           o_dbusReq,
    output logic                     o_busy,
    output CorePkg::MemPayloadT      o_out
);

    logic [CorePkg::XLEN-1:0] r_loadData;
    logic                     r_done;
    logic                     w_memOp;
    logic                     w_request;

    assign w_memOp = i_in.isLoad || i_in.isStore;

    // Request stays up until ack, then drops for the cycle the stage drains
    assign w_request = w_memOp && !r_done;
    assign o_busy = w_request;

    // Address and data come straight from the frozen stage register
    assign o_dbusReq = '{
        adr:    i_in.aluResult,
        datW:   i_in.storeData,
        we:     i_in.isStore,
        cycStb: w_request
    };

    // Access is complete for the one cycle after ack, while the stage moves on
    always_ff @(posedge i_Clk) begin
        if (i_reset) begin
            r_done <= 1'b0;
        end else begin
            r_done <= w_request && i_dbusAck;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (w_request && i_dbusAck) begin
            r_loadData <= i_dbusDat;
        end
    end

    always_comb begin
        o_out = i_in;
        if (i_in.isLoad) begin
            o_out.aluResult = r_loadData;
        end
    end

endmodule

// File: source/ExecuteStage.sv
`timescale 1ns/10ps

module ExecuteStage (
    input  CorePkg::ExecPayloadT i_in,
    input  CorePkg::MemPayloadT  i_fwdM,
    input  CorePkg::MemPayloadT  i_fwdW,
    output CorePkg::MemPayloadT  o_out
);

    logic [CorePkg::XLEN-1:0] w_opA;
    logic [CorePkg::XLEN-1:0] w_rs2Fwd;
    logic [CorePkg::XLEN-1:0] w_opB;

    // Memory stage is younger than writeback, so it is checked last and wins
    function automatic logic [CorePkg::XLEN-1:0] pickOperand(
        input CorePkg::RegAddrT         rs,
        input logic [CorePkg::XLEN-1:0] regValue,
        input CorePkg::MemPayloadT      fwdM,
        input CorePkg::MemPayloadT      fwdW
    );
        logic [CorePkg::XLEN-1:0] value;
        value = regValue;
        if (fwdW.writesRd && !fwdW.isLoad && fwdW.rd == rs) begin
            value = fwdW.aluResult;
        end
        if (fwdM.writesRd && !fwdM.isLoad && fwdM.rd == rs) begin
            value = fwdM.aluResult;
        end
        return value;
    endfunction

    assign w_opA = pickOperand(i_in.rs1, i_in.rs1Value, i_fwdM, i_fwdW);
    assign w_rs2Fwd = pickOperand(i_in.rs2, i_in.rs2Value, i_fwdM, i_fwdW);
    assign w_opB = i_in.useImm ? i_in.imm : w_rs2Fwd;

    always_comb begin
        o_out = '0;
        // ADDI, ADD and load/store address share the adder
        o_out.aluResult = (i_in.aluSel == CorePkg::ALU_ADD) ? (w_opA + w_opB) : w_opB;
        o_out.storeData = w_rs2Fwd;
        o_out.branchTarget = i_in.pc + i_in.imm;
        o_out.rd = i_in.rd;
        o_out.isLoad = i_in.isLoad;
        o_out.isStore = i_in.isStore;
        o_out.isBranch = i_in.isBranch;
        o_out.takeBranch = i_in.isBranch && (w_opA == w_rs2Fwd);
        o_out.writesRd = i_in.writesRd;
    end

endmodule

// File: source/DecodeStage.sv
`timescale 1ns/10ps

module DecodeStage (
    input  logic                     i_Clk,
    input  logic                     i_reset,
    input  CorePkg::DecodePayloadT   i_in,
    input  logic                     i_wbWe,
    input  CorePkg::RegAddrT         i_wbRd,
    input  logic [CorePkg::XLEN-1:0] i_wbData,
    output CorePkg::ExecPayloadT     o_out,
    output logic                     o_rs1Valid,
    output logic                     o_rs2Valid
);

    logic [CorePkg::XLEN-1:0] r_regs [32];
    logic [6:0]               w_opcode;
    CorePkg::RegAddrT         w_rs1;
    CorePkg::RegAddrT         w_rs2;
    CorePkg::RegAddrT         w_rd;
    logic [CorePkg::XLEN-1:0] w_immI;
    logic [CorePkg::XLEN-1:0] w_immS;
    logic [CorePkg::XLEN-1:0] w_immB;
    logic [CorePkg::XLEN-1:0] w_rs1Value;
    logic [CorePkg::XLEN-1:0] w_rs2Value;
    logic                     w_readsRs1;
    logic                     w_readsRs2;
    logic                     w_writes;

    assign w_opcode = i_in.instr[6:0];
    assign w_rd = i_in.instr[11:7];
    assign w_rs1 = i_in.instr[19:15];
    assign w_rs2 = i_in.instr[24:20];

    assign w_immI = {{20{i_in.instr[31]}}, i_in.instr[31:20]};
    assign w_immS = {{20{i_in.instr[31]}}, i_in.instr[31:25], i_in.instr[11:7]};
    assign w_immB = {{19{i_in.instr[31]}}, i_in.instr[31], i_in.instr[7],
                     i_in.instr[30:25], i_in.instr[11:8], 1'b0};

    // x0 reads zero; a write in this cycle bypasses the array
    assign w_rs1Value = (w_rs1 == '0) ? '0 :
                        (i_wbWe && i_wbRd == w_rs1) ? i_wbData : r_regs[w_rs1];
    assign w_rs2Value = (w_rs2 == '0) ? '0 :
                        (i_wbWe && i_wbRd == w_rs2) ? i_wbData : r_regs[w_rs2];

    always_comb begin
        o_out = '0;
        o_out.pc = i_in.pc;
        o_out.rs1 = w_rs1;
        o_out.rs2 = w_rs2;
        o_out.rd = w_rd;
        o_out.rs1Value = w_rs1Value;
        o_out.rs2Value = w_rs2Value;
        w_readsRs1 = 1'b0;
        w_readsRs2 = 1'b0;
        w_writes = 1'b0;
        case (w_opcode)
            CorePkg::OP_IMM: begin
                o_out.imm = w_immI;
                o_out.useImm = 1'b1;
                w_readsRs1 = 1'b1;
                w_writes = 1'b1;
            end
            CorePkg::OP_REG: begin
                w_readsRs1 = 1'b1;
                w_readsRs2 = 1'b1;
                w_writes = 1'b1;
            end
            CorePkg::OP_LOAD: begin
                o_out.imm = w_immI;
                o_out.useImm = 1'b1;
                o_out.isLoad = 1'b1;
                w_readsRs1 = 1'b1;
                w_writes = 1'b1;
            end
            CorePkg::OP_STORE: begin
                o_out.imm = w_immS;
                o_out.useImm = 1'b1;
                o_out.isStore = 1'b1;
                w_readsRs1 = 1'b1;
                w_readsRs2 = 1'b1;
            end
            CorePkg::OP_BRANCH: begin
                o_out.imm = w_immB;
                o_out.aluSel = CorePkg::ALU_PASS_B;
                o_out.isBranch = 1'b1;
                w_readsRs1 = 1'b1;
                w_readsRs2 = 1'b1;
            end
            // Anything else, including a bubble, decodes to a no-op
            default: ;
        endcase
        o_out.writesRd = w_writes && (w_rd != '0);
    end

    // Hazard checks skip x0 reads
    assign o_rs1Valid = w_readsRs1 && (w_rs1 != '0);
    assign o_rs2Valid = w_readsRs2 && (w_rs2 != '0);

    always_ff @(posedge i_Clk) begin
        if (i_reset) begin
            for (int i = 0; i < 32; i++) begin
                r_regs[i] <= '0;
            end
        end else if (i_wbWe && i_wbRd != '0) begin
            r_regs[i_wbRd] <= i_wbData;
        end
    end

endmodule

// File: source/FetchUnit.sv
`timescale 1ns/10ps

module FetchUnit #(
    parameter logic [CorePkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                     i_Clk,
    input  logic                     i_reset,
    input  logic                     i_pcEn,
    input  logic                     i_redirect,
    input  logic [CorePkg::XLEN-1:0] i_redirectPc,
    input  logic                     i_ibusAck,
    input  logic [CorePkg::XLEN-1:0] i_ibusDat,
    output CorePkg::WbReqT           o_ibusReq,
    output CorePkg::DecodePayloadT   o_fetched,
    output logic                     o_fetchValid,
    output logic                     o_waitReq
);

    logic [CorePkg::XLEN-1:0] r_pc;
    logic [CorePkg::XLEN-1:0] r_adr;
    logic [CorePkg::XLEN-1:0] r_buf;
    logic                     r_cyc;
    logic                     r_bufValid;
    logic                     r_discard;
    logic [CorePkg::XLEN-1:0] w_pcNext;
    logic                     w_bufValidNext;
    logic                     w_ackGood;
    logic                     w_pending;
    logic                     w_consume;

    // A read that was in flight across a redirect is dropped on its ack
    assign w_ackGood = r_cyc && i_ibusAck && !r_discard;
    assign w_pending = r_cyc && !i_ibusAck;
    assign o_fetchValid = r_bufValid || w_ackGood;
    assign o_waitReq = !o_fetchValid;
    assign w_consume = i_pcEn && o_fetchValid && !i_redirect;

    // r_pc always names the instruction being fetched or buffered
    assign o_fetched = '{pc: r_pc, instr: (r_bufValid ? r_buf : i_ibusDat)};
    assign o_ibusReq = '{adr: r_adr, datW: '0, we: 1'b0, cycStb: r_cyc};

    always_comb begin
        w_pcNext = r_pc;
        w_bufValidNext = r_bufValid;
        if (i_redirect) begin
            w_pcNext = i_redirectPc;
            w_bufValidNext = 1'b0;
        end else if (w_consume) begin
            w_pcNext = r_pc + 32'd4;
            w_bufValidNext = 1'b0;
        end else if (w_ackGood) begin
            // Pipeline is holding, park the word until decode takes it
            w_bufValidNext = 1'b1;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (i_reset) begin
            r_pc <= RESET_PC;
            r_cyc <= 1'b0;
            r_bufValid <= 1'b0;
            r_discard <= 1'b0;
        end else begin
            r_pc <= w_pcNext;
            r_bufValid <= w_bufValidNext;
            // Keep a pending read, otherwise start one whenever the buffer is free
            r_cyc <= w_pending || !w_bufValidNext;
            r_discard <= w_pending && (r_discard || i_redirect);
        end
    end

    // Address stays put while a read waits for ack
    always_ff @(posedge i_Clk) begin
        if (!w_pending) begin
            r_adr <= w_pcNext;
        end
        if (w_ackGood) begin
            r_buf <= i_ibusDat;
        end
    end

endmodule

// File: source/StageReg.sv
`timescale 1ns/10ps

module StageReg #(
    parameter type PayloadT = logic
) (
    input  logic    i_Clk,
    input  logic    i_reset,
    input  logic    i_en,
    input  logic    i_clr,
    input  PayloadT i_d,
    output PayloadT o_q
);

    // An all-zero payload is a bubble, clear takes priority over load
    always_ff @(posedge i_Clk) begin
        if (i_reset || i_clr) begin
            o_q <= '0;
        end else if (i_en) begin
            o_q <= i_d;
        end
    end

endmodule

// File: source/CorePkg.sv
package CorePkg;

    // Datapath and address width
    localparam int XLEN = 32;

    typedef logic [4:0] RegAddrT;

    // Pass-B only matters for BEQ, whose result is never written
    typedef enum logic {
        ALU_ADD    = 1'b0,
        ALU_PASS_B = 1'b1
    } AluSelT;

    // RV32I major opcodes for the supported subset
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // Fetch to decode
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } DecodePayloadT;

    // Decode to execute
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1Value;
        logic [XLEN-1:0] rs2Value;
        logic [XLEN-1:0] imm;
        RegAddrT         rs1;
        RegAddrT         rs2;
        RegAddrT         rd;
        AluSelT          aluSel;
        logic            useImm;
        logic            isLoad;
        logic            isStore;
        logic            isBranch;
        logic            writesRd;
    } ExecPayloadT;

    // Execute to memory, and memory to writeback with load data in aluResult
    typedef struct packed {
        logic [XLEN-1:0] aluResult;
        logic [XLEN-1:0] storeData;
        logic [XLEN-1:0] branchTarget;
        RegAddrT         rd;
        logic            isLoad;
        logic            isStore;
        logic            isBranch;
        logic            takeBranch;
        logic            writesRd;
    } MemPayloadT;

    // Master to slave half of a Wishbone classic bus
    typedef struct packed {
        logic [XLEN-1:0] adr;
        logic [XLEN-1:0] datW;
        logic            we;
        logic            cycStb;
    } WbReqT;

endpackage
